/* logic/fetch_icache.sv */
// Instruction cache
// Direct-mapped, registered lookup with the result one cycle later, whole-line fill

`timescale 1ns/100ps

module fetch_icache import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_lookup_en,
    input  logic [ADDR_WIDTH-1:0] i_lookup_addr,
    output logic                  o_hit,
    output logic [INSN_WIDTH-1:0] o_data,
    input  logic                  i_fill_en,
    input  logic [ADDR_WIDTH-1:0] i_fill_addr,
    input  logic [LINE_WIDTH-1:0] i_fill_data
);

    logic [LINE_WIDTH-1:0]        line_data [IC_LINES];
    logic [IC_TAG_WIDTH-1:0]      line_tag [IC_LINES];
    logic [IC_LINES-1:0]          line_valid;

    logic                         lookup_r;
    logic [IC_INDEX_WIDTH-1:0]    index_r;
    logic [IC_TAG_WIDTH-1:0]      tag_r;
    logic [IC_WORD_SEL_WIDTH-1:0] word_r;

    logic [IC_INDEX_WIDTH-1:0]    lookup_index;
    logic [IC_TAG_WIDTH-1:0]      lookup_tag;
    logic [IC_INDEX_WIDTH-1:0]    fill_index;
    logic [IC_TAG_WIDTH-1:0]      fill_tag;
    logic [LINE_WIDTH-1:0]        sel_line;

    assign lookup_index = i_lookup_addr[IC_OFFSET_WIDTH +: IC_INDEX_WIDTH];
    assign lookup_tag   = i_lookup_addr[ADDR_WIDTH-1 -: IC_TAG_WIDTH];
    assign fill_index   = i_fill_addr[IC_OFFSET_WIDTH +: IC_INDEX_WIDTH];
    assign fill_tag     = i_fill_addr[ADDR_WIDTH-1 -: IC_TAG_WIDTH];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            line_valid <= '0;
            lookup_r   <= 1'b0;
        end else begin
            lookup_r <= i_lookup_en;
            if (i_fill_en) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    // Line storage and the captured lookup fields
    always_ff @(posedge clk) begin
        if (i_fill_en) begin
            line_data[fill_index] <= i_fill_data;
            line_tag[fill_index]  <= fill_tag;
        end
        if (i_lookup_en) begin
            index_r <= lookup_index;
            tag_r   <= lookup_tag;
            word_r  <= i_lookup_addr[IC_OFFSET_WIDTH-1 -: IC_WORD_SEL_WIDTH];
        end
    end

    // Arrays are read from the registered index, so a fill lands before the compare
    assign sel_line = line_data[index_r];
    assign o_hit    = lookup_r & line_valid[index_r] & (line_tag[index_r] == tag_r);

    // Word 0 of a line sits in the low bits
    assign o_data = sel_line[word_r * INSN_WIDTH +: INSN_WIDTH];

endmodule

/* logic/fetch_miss_handler.sv */
// Instruction miss handler
// Single outstanding line request to memory, returned to the cache as a fill pulse

`timescale 1ns/100ps

module fetch_miss_handler import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_alloc_en,
    input  logic [ADDR_WIDTH-1:0] i_alloc_addr,
    output logic                  o_ifq_full,
    output logic                  o_mem_req,
    output logic [ADDR_WIDTH-1:0] o_mem_addr,
    input  logic                  i_mem_valid,
    input  logic [LINE_WIDTH-1:0] i_mem_data,
    output logic                  o_fill_en,
    output logic [ADDR_WIDTH-1:0] o_fill_addr,
    output logic [LINE_WIDTH-1:0] o_fill_data
);

    miss_state_t           state_r;
    miss_state_t           state_next;
    logic [ADDR_WIDTH-1:0] line_addr_r;
    logic [LINE_WIDTH-1:0] line_data_r;
    logic                  take_alloc;
    logic                  take_resp;

    assign take_alloc = (state_r == MISS_IDLE) & i_alloc_en;
    assign take_resp  = (state_r == MISS_REQ) & i_mem_valid;

    always_comb begin
        state_next = state_r;
        case (state_r)
            MISS_IDLE: begin
                if (i_alloc_en) begin
                    state_next = MISS_REQ;
                end
            end
            MISS_REQ: begin
                if (i_mem_valid) begin
                    state_next = MISS_FILL;
                end
            end
            // Fill lasts exactly one cycle
            MISS_FILL: state_next = MISS_IDLE;
            default:   state_next = MISS_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= MISS_IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (take_alloc) begin
            line_addr_r <= {i_alloc_addr[ADDR_WIDTH-1:IC_OFFSET_WIDTH], {IC_OFFSET_WIDTH{1'b0}}};
        end
        if (take_resp) begin
            line_data_r <= i_mem_data;
        end
    end

    // Busy from the cycle after the alloc up to and including the fill
    assign o_ifq_full = (state_r != MISS_IDLE);

    assign o_mem_req   = (state_r == MISS_REQ);
    assign o_mem_addr  = line_addr_r;
    assign o_fill_en   = (state_r == MISS_FILL);
    assign o_fill_addr = line_addr_r;
    assign o_fill_data = line_data_r;

endmodule

/* logic/fetch_pipeline.sv */
// Fetch pipeline
// PC generation, IT and IR stages, and the FSM for misses and a full instruction FIFO

`timescale 1ns/100ps

module fetch_pipeline import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_redirect,
    input  logic [ADDR_WIDTH-1:0] i_redirect_addr,
    input  logic                  i_ifq_full,
    input  logic                  i_fill_en,
    output logic                  o_alloc_en,
    output logic [ADDR_WIDTH-1:0] o_alloc_addr,
    output logic                  o_ic_en,
    output logic [ADDR_WIDTH-1:0] o_ic_addr,
    input  logic                  i_ic_hit,
    input  logic [INSN_WIDTH-1:0] i_ic_data,
    input  logic                  i_fifo_full,
    output logic                  o_fifo_we,
    output logic [ADDR_WIDTH-1:0] o_fifo_pc,
    output logic [INSN_WIDTH-1:0] o_fifo_insn
);

    fetch_state_t          state_r;
    fetch_state_t          state_next;

    logic [ADDR_WIDTH-1:0] pc_r;
    logic [ADDR_WIDTH-1:0] pc_next;
    logic [ADDR_WIDTH-1:0] it_addr_r;
    logic [ADDR_WIDTH-1:0] ir_addr_r;
    logic [ADDR_WIDTH-1:0] replay_pc_r;

    logic                  running;
    logic                  it_valid;
    logic                  it_valid_r;
    logic                  ir_valid;
    logic                  ir_valid_r;
    logic                  fetch_valid;
    logic                  hit;
    logic                  miss;
    logic                  drop;
    logic                  alloc;

    assign running = (state_r == FETCH_NEXT);

    // A PC only advances through the stages while the FSM keeps fetching
    assign it_valid    = running & ~i_redirect;
    assign ir_valid    = it_valid_r & running & ~i_redirect;
    assign fetch_valid = ir_valid_r & running & ~i_redirect;

    assign hit   = fetch_valid & i_ic_hit;
    assign miss  = fetch_valid & ~i_ic_hit;
    assign drop  = hit & i_fifo_full;
    assign alloc = (state_r == FETCH_MISS_ENQ) & ~i_ifq_full & ~i_redirect;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            it_valid_r <= 1'b0;
            ir_valid_r <= 1'b0;
        end else begin
            it_valid_r <= it_valid;
            ir_valid_r <= ir_valid;
        end
    end

    // Stage addresses, plus the PC to restart from after a miss or a dropped write
    always_ff @(posedge clk) begin
        it_addr_r <= pc_r;
        ir_addr_r <= it_addr_r;
        if (miss | drop) begin
            replay_pc_r <= ir_addr_r;
        end
    end

    always_comb begin
        state_next = state_r;
        case (state_r)
            FETCH_NEXT: begin
                if (miss) begin
                    state_next = FETCH_MISS_ENQ;
                end else if (drop) begin
                    state_next = FETCH_FIFO_STALL;
                end
            end
            // Wait here while an older line request is still in flight
            FETCH_MISS_ENQ: begin
                if (alloc) begin
                    state_next = FETCH_MISS_WAIT;
                end
            end
            FETCH_MISS_WAIT: begin
                if (i_fill_en) begin
                    state_next = FETCH_NEXT;
                end
            end
            FETCH_FIFO_STALL: begin
                if (!i_fifo_full) begin
                    state_next = FETCH_NEXT;
                end
            end
            default: state_next = FETCH_NEXT;
        endcase

        // Redirect wins over any pending miss or stall
        if (i_redirect) begin
            state_next = FETCH_NEXT;
        end
    end

    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_addr;
        end else if (running) begin
            pc_next = pc_r + ADDR_WIDTH'(INSN_BYTES);
        end else begin
            pc_next = replay_pc_r;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= FETCH_NEXT;
            pc_r    <= RESET_PC;
        end else begin
            state_r <= state_next;
            pc_r    <= pc_next;
        end
    end

    // Tag lookup from IT, result consumed in IR
    assign o_ic_en   = it_valid_r;
    assign o_ic_addr = it_addr_r;

    assign o_fifo_we   = hit & ~i_fifo_full;
    assign o_fifo_pc   = ir_addr_r;
    assign o_fifo_insn = i_ic_data;

    assign o_alloc_en   = alloc;
    assign o_alloc_addr = replay_pc_r;

endmodule

/* logic/fetch_pkg.sv */
// Fetch subsystem definitions
// Widths, cache geometry, FIFO sizing and the state encodings

package fetch_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int INSN_WIDTH = 32;
    localparam int INSN_BYTES = INSN_WIDTH / 8;

    // Direct-mapped cache, four instructions per line
    localparam int LINE_BYTES        = 16;
    localparam int LINE_WIDTH        = LINE_BYTES * 8;
    localparam int IC_LINES          = 16;
    localparam int IC_INDEX_WIDTH    = 4;
    localparam int IC_OFFSET_WIDTH   = 4;
    localparam int IC_TAG_WIDTH      = ADDR_WIDTH - IC_INDEX_WIDTH - IC_OFFSET_WIDTH;
    localparam int IC_WORD_SEL_WIDTH = 2;

    localparam int INSN_FIFO_DEPTH     = 8;
    localparam int INSN_FIFO_PTR_WIDTH = 3;
    localparam int INSN_FIFO_CNT_WIDTH = 4;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;

    localparam int FETCH_STATE_WIDTH = 2;
    localparam int MISS_STATE_WIDTH  = 2;

    typedef enum logic [FETCH_STATE_WIDTH-1:0] {
        FETCH_NEXT       = 2'b00,
        FETCH_MISS_ENQ   = 2'b01,
        FETCH_MISS_WAIT  = 2'b10,
        FETCH_FIFO_STALL = 2'b11
    } fetch_state_t;

    typedef enum logic [MISS_STATE_WIDTH-1:0] {
        MISS_IDLE = 2'b00,
        MISS_REQ  = 2'b01,
        MISS_FILL = 2'b10
    } miss_state_t;

endpackage

/* logic/fetch_top.sv */
// Instruction fetch subsystem top level
// Miss handler, fetch pipeline with its cache, and the decode-facing FIFO

`timescale 1ns/100ps

module fetch_top import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_redirect,
    input  logic [ADDR_WIDTH-1:0] i_redirect_addr,
    input  logic                  i_decode_stall,
    output logic                  o_mem_req,
    output logic [ADDR_WIDTH-1:0] o_mem_addr,
    input  logic                  i_mem_valid,
    input  logic [LINE_WIDTH-1:0] i_mem_data,
    output logic                  o_fetch_valid,
    output logic [ADDR_WIDTH-1:0] o_fetch_pc,
    output logic [INSN_WIDTH-1:0] o_fetch_insn
);

    logic                  alloc_en;
    logic [ADDR_WIDTH-1:0] alloc_addr;
    logic                  ifq_full;
    logic                  fill_en;
    logic [ADDR_WIDTH-1:0] fill_addr;
    logic [LINE_WIDTH-1:0] fill_data;
    logic                  ic_en;
    logic [ADDR_WIDTH-1:0] ic_addr;
    logic                  ic_hit;
    logic [INSN_WIDTH-1:0] ic_data;
    logic                  fifo_we;
    logic [ADDR_WIDTH-1:0] fifo_pc;
    logic [INSN_WIDTH-1:0] fifo_insn;
    logic                  fifo_full;

    fetch_miss_handler u_miss_handler (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_alloc_en   (alloc_en),
        .i_alloc_addr (alloc_addr),
        .o_ifq_full   (ifq_full),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .i_mem_valid  (i_mem_valid),
        .i_mem_data   (i_mem_data),
        .o_fill_en    (fill_en),
        .o_fill_addr  (fill_addr),
        .o_fill_data  (fill_data)
    );

    fetch_pipeline u_pipeline (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_ifq_full      (ifq_full),
        .i_fill_en       (fill_en),
        .o_alloc_en      (alloc_en),
        .o_alloc_addr    (alloc_addr),
        .o_ic_en         (ic_en),
        .o_ic_addr       (ic_addr),
        .i_ic_hit        (ic_hit),
        .i_ic_data       (ic_data),
        .i_fifo_full     (fifo_full),
        .o_fifo_we       (fifo_we),
        .o_fifo_pc       (fifo_pc),
        .o_fifo_insn     (fifo_insn)
    );

    fetch_icache u_icache (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_lookup_en   (ic_en),
        .i_lookup_addr (ic_addr),
        .o_hit         (ic_hit),
        .o_data        (ic_data),
        .i_fill_en     (fill_en),
        .i_fill_addr   (fill_addr),
        .i_fill_data   (fill_data)
    );

    // Redirect also empties the FIFO and its output stage
    insn_fifo u_insn_fifo (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_redirect),
        .i_we           (fifo_we),
        .i_pc           (fifo_pc),
        .i_insn         (fifo_insn),
        .o_full         (fifo_full),
        .i_decode_stall (i_decode_stall),
        .o_fetch_valid  (o_fetch_valid),
        .o_fetch_pc     (o_fetch_pc),
        .o_fetch_insn   (o_fetch_insn)
    );

endmodule

/* logic/insn_fifo.sv */
// Instruction FIFO
// Circular buffer of PC and instruction pairs with a registered decode output stage

`timescale 1ns/100ps

module insn_fifo import fetch_pkg::*; (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_we,
    input  logic [ADDR_WIDTH-1:0] i_pc,
    input  logic [INSN_WIDTH-1:0] i_insn,
    output logic                  o_full,
    input  logic                  i_decode_stall,
    output logic                  o_fetch_valid,
    output logic [ADDR_WIDTH-1:0] o_fetch_pc,
    output logic [INSN_WIDTH-1:0] o_fetch_insn
);

    logic [ADDR_WIDTH-1:0]          pc_mem [INSN_FIFO_DEPTH];
    logic [INSN_WIDTH-1:0]          insn_mem [INSN_FIFO_DEPTH];
    logic [INSN_FIFO_PTR_WIDTH-1:0] wr_ptr_r;
    logic [INSN_FIFO_PTR_WIDTH-1:0] rd_ptr_r;
    logic [INSN_FIFO_CNT_WIDTH-1:0] count_r;
    logic                           empty;
    logic                           push;
    logic                           pop;

    assign o_full = (count_r == INSN_FIFO_CNT_WIDTH'(INSN_FIFO_DEPTH));
    assign empty  = (count_r == '0);
    assign push   = i_we & ~o_full & ~i_flush;

    // Head moves to the output stage whenever decode is accepting
    assign pop = ~empty & ~i_decode_stall & ~i_flush;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr_r      <= '0;
            rd_ptr_r      <= '0;
            count_r       <= '0;
            o_fetch_valid <= 1'b0;
        end else if (i_flush) begin
            wr_ptr_r      <= '0;
            rd_ptr_r      <= '0;
            count_r       <= '0;
            o_fetch_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (pop) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: count_r <= count_r;
            endcase
            if (!i_decode_stall) begin
                o_fetch_valid <= pop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr_r]   <= i_pc;
            insn_mem[wr_ptr_r] <= i_insn;
        end
        if (pop) begin
            o_fetch_pc   <= pc_mem[rd_ptr_r];
            o_fetch_insn <= insn_mem[rd_ptr_r];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build the fetch testbench with Verilator, run it and scan the log for a failure

verilator --binary --timing --assert --timescale 1ns/100ps -f sources.f \
    --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation ended abnormally"; exit 1; }

cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported a failure"; exit 1; }
exit 0

/* sources.f */
logic/fetch_pkg.sv
logic/fetch_icache.sv
logic/fetch_miss_handler.sv
logic/fetch_pipeline.sv
logic/insn_fifo.sv
logic/fetch_top.sv
tests/fetch_asserts.sv
tests/fetch_tb.sv

/* tests/fetch_asserts.sv */
// Handshake assertions for the fetch subsystem top level
// Memory request stability, decode stall hold and idle outputs in reset

`timescale 1ns/100ps

module fetch_asserts import fetch_pkg::*; (
    input logic                  clk,
    input logic                  i_rst_n,
    input logic                  i_redirect,
    input logic                  i_decode_stall,
    input logic                  o_mem_req,
    input logic [ADDR_WIDTH-1:0] o_mem_addr,
    input logic                  i_mem_valid,
    input logic                  o_fetch_valid,
    input logic [ADDR_WIDTH-1:0] o_fetch_pc,
    input logic [INSN_WIDTH-1:0] o_fetch_insn
);

    // Line requests carry an aligned address
    a_mem_addr_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_mem_req |-> (o_mem_addr[IC_OFFSET_WIDTH-1:0] == '0))
        else $error("memory request address is not line aligned");

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_mem_req && !i_mem_valid) |=> (o_mem_req && $stable(o_mem_addr)))
        else $error("memory request dropped or changed before the response");

    // A stalled decode output keeps its instruction
    a_stall_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_fetch_valid && i_decode_stall && !i_redirect) |=>
        (o_fetch_valid && $stable(o_fetch_pc) && $stable(o_fetch_insn)))
        else $error("decode output changed while stalled");

    a_reset_idle: assert property (@(posedge clk)
        !i_rst_n |-> (!o_fetch_valid && !o_mem_req))
        else $error("fetch valid or memory request high during reset");

endmodule

/* tests/fetch_tb.sv */
// Fetch subsystem testbench
// Random redirects, decode stalls and memory delays checked against a PC stream model

`timescale 1ns/100ps

module fetch_tb import fetch_pkg::*; ();

    localparam logic [INSN_WIDTH-1:0] INSN_KEY    = 32'h5a3c_96e1;
    localparam logic [ADDR_WIDTH-1:0] REGION_BASE = 32'h0000_0800;

    localparam int FIRST_PASS       = 48;
    localparam int SECOND_PASS      = 32;
    localparam int REDIRECTS        = 16;
    localparam int AFTER_REDIRECT   = 8;
    localparam int DELIVERY_WINDOW  = 200;
    localparam int SEQ_LEN          = 64;
    localparam int REFILL_LEN       = FIRST_PASS + SECOND_PASS;
    localparam int REDIRECT_LEN     = REDIRECTS * AFTER_REDIRECT;
    localparam int BACKPRESSURE_LEN = 200;
    localparam int MIXED_LEN        = 2000;
    localparam int TIMEOUT_CYCLES   =
        (SEQ_LEN + REFILL_LEN + REDIRECT_LEN + BACKPRESSURE_LEN + MIXED_LEN) * 20;

    logic                  clk;
    logic                  i_rst_n;
    logic                  i_redirect;
    logic [ADDR_WIDTH-1:0] i_redirect_addr;
    logic                  i_decode_stall;
    logic                  o_mem_req;
    logic [ADDR_WIDTH-1:0] o_mem_addr;
    logic                  i_mem_valid;
    logic [LINE_WIDTH-1:0] i_mem_data;
    logic                  o_fetch_valid;
    logic [ADDR_WIDTH-1:0] o_fetch_pc;
    logic [INSN_WIDTH-1:0] o_fetch_insn;

    // Reference and memory model state
    logic [ADDR_WIDTH-1:0] exp_pc;
    logic [ADDR_WIDTH-1:0] mem_line;
    logic                  mem_busy;
    logic                  req_seen;
    logic                  track_req;
    int                    mem_delay;
    int                    req_rises;
    int                    delivery_count;
    int                    idle_cycles;
    int                    check_count;
    int                    error_count;
    int                    cycle_count;
    string                 test_name;

    fetch_top UUT (
        .clk             (clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_addr (i_redirect_addr),
        .i_decode_stall  (i_decode_stall),
        .o_mem_req       (o_mem_req),
        .o_mem_addr      (o_mem_addr),
        .i_mem_valid     (i_mem_valid),
        .i_mem_data      (i_mem_data),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_insn    (o_fetch_insn)
    );

    bind fetch_top fetch_asserts u_asserts (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_redirect     (i_redirect),
        .i_decode_stall (i_decode_stall),
        .o_mem_req      (o_mem_req),
        .o_mem_addr     (o_mem_addr),
        .i_mem_valid    (i_mem_valid),
        .o_fetch_valid  (o_fetch_valid),
        .o_fetch_pc     (o_fetch_pc),
        .o_fetch_insn   (o_fetch_insn)
    );

    // Memory content rule for the instruction at a byte address
    function automatic logic [INSN_WIDTH-1:0] insn_at(input logic [ADDR_WIDTH-1:0] addr);
        return (addr * 3) ^ INSN_KEY;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_at(input logic [ADDR_WIDTH-1:0] base);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < LINE_BYTES / INSN_BYTES; w++) begin
            line[w * INSN_WIDTH +: INSN_WIDTH] = insn_at(base + ADDR_WIDTH'(w * INSN_BYTES));
        end
        return line;
    endfunction

    function automatic logic random_chance(input int unsigned percent);
        return $urandom_range(99, 0) < percent;
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
        end
    endtask

    // Drives one cycle of inputs, scores what the DUT shows in it, then moves to the next cycle
    task automatic run_cycle(input logic redir, input logic [ADDR_WIDTH-1:0] raddr,
                             input logic stall);
        logic [ADDR_WIDTH-1:0] next_line;
        logic                  in_window;
        i_redirect      = redir;
        i_redirect_addr = raddr;
        i_decode_stall  = stall;
        i_mem_valid     = 1'b0;
        if (o_mem_req && !mem_busy) begin
            mem_busy  = 1'b1;
            mem_delay = $urandom_range(6, 1);
            mem_line  = o_mem_addr;
        end
        if (mem_busy) begin
            mem_delay = mem_delay - 1;
            if (mem_delay == 0) begin
                i_mem_valid = 1'b1;
                i_mem_data  = line_at(mem_line);
                mem_busy    = 1'b0;
            end
        end
        // A new request must fetch a line the stream has not yet delivered
        if (o_mem_req && !req_seen) begin
            req_rises++;
            if (track_req) begin
                next_line = {exp_pc[ADDR_WIDTH-1:IC_OFFSET_WIDTH], {IC_OFFSET_WIDTH{1'b0}}};
                in_window = (o_mem_addr[IC_OFFSET_WIDTH-1:0] == '0) &&
                            (o_mem_addr >= next_line) && (o_mem_addr < exp_pc + 64);
                compare_value({test_name, " request in window"}, 32'd1, 32'(in_window));
            end
        end
        req_seen = o_mem_req;
        if (o_fetch_valid && !stall && !redir) begin
            compare_value({test_name, " pc"}, exp_pc, o_fetch_pc);
            compare_value({test_name, " insn"}, insn_at(exp_pc), o_fetch_insn);
            exp_pc = exp_pc + 4;
            delivery_count++;
            idle_cycles = 0;
        end else begin
            idle_cycles++;
        end
        if (redir) begin
            exp_pc = raddr;
        end
        @(posedge clk);
        #10;
    endtask

    task automatic report_test(input int errors_before, input int delivered_before);
        $display("%s: %s, %0d delivered, %0d errors", test_name,
                 (error_count == errors_before) ? "passed" : "failed",
                 delivery_count - delivered_before, error_count - errors_before);
    endtask

    task automatic sequential_stream();
        int errors_before;
        int start;
        errors_before = error_count;
        start         = delivery_count;
        test_name     = "sequential_stream";
        track_req     = 1'b1;
        while (delivery_count - start < SEQ_LEN) begin
            run_cycle(1'b0, '0, 1'b0);
        end
        report_test(errors_before, start);
    endtask

    task automatic miss_refill();
        int errors_before;
        int start;
        int pass_start;
        errors_before = error_count;
        start         = delivery_count;
        test_name     = "miss_refill";
        track_req     = 1'b1;
        run_cycle(1'b1, REGION_BASE, 1'b0);
        pass_start = delivery_count;
        while (delivery_count - pass_start < FIRST_PASS) begin
            run_cycle(1'b0, '0, 1'b0);
        end
        // Second pass stays inside lines already filled by the first
        run_cycle(1'b1, REGION_BASE, 1'b0);
        req_rises  = 0;
        pass_start = delivery_count;
        while (delivery_count - pass_start < SECOND_PASS) begin
            run_cycle(1'b0, '0, 1'b0);
        end
        compare_value({test_name, " second pass requests"}, 0, req_rises);
        report_test(errors_before, start);
    endtask

    task automatic redirect_stream();
        int                    errors_before;
        int                    start;
        int                    waited;
        logic [ADDR_WIDTH-1:0] target;
        errors_before = error_count;
        start         = delivery_count;
        test_name     = "redirect";
        track_req     = 1'b0;
        for (int i = 0; i < REDIRECTS; i++) begin
            waited = 0;
            // Even rounds hit an outstanding miss, odd rounds a busy decode output
            while (!((i % 2 == 0) ? o_mem_req : o_fetch_valid) && waited < 40) begin
                run_cycle(1'b0, '0, random_chance(30));
                waited++;
            end
            target = $urandom_range(1023, 0) * 4;
            run_cycle(1'b1, target, random_chance(30));
            waited = delivery_count;
            while (delivery_count - waited < AFTER_REDIRECT) begin
                run_cycle(1'b0, '0, random_chance(30));
            end
        end
        report_test(errors_before, start);
    endtask

    task automatic decode_backpressure();
        int errors_before;
        int start;
        errors_before = error_count;
        start         = delivery_count;
        test_name     = "decode_backpressure";
        track_req     = 1'b1;
        while (delivery_count - start < BACKPRESSURE_LEN) begin
            run_cycle(1'b0, '0, random_chance(60));
        end
        report_test(errors_before, start);
    endtask

    task automatic mixed_random();
        int                    errors_before;
        int                    start;
        logic                  redir;
        logic [ADDR_WIDTH-1:0] target;
        errors_before = error_count;
        start         = delivery_count;
        test_name     = "mixed_random";
        track_req     = 1'b0;
        idle_cycles   = 0;
        for (int n = 0; n < MIXED_LEN; n++) begin
            redir  = ($urandom_range(127, 0) == 0);
            target = $urandom_range(1023, 0) * 4;
            run_cycle(redir, target, random_chance(40));
            if (idle_cycles == DELIVERY_WINDOW) begin
                error_count++;
                $display("%s: no instruction delivered in %0d cycles", test_name,
                         DELIVERY_WINDOW);
            end
        end
        report_test(errors_before, start);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(25601));
        i_rst_n         = 1'b0;
        i_redirect      = 1'b0;
        i_redirect_addr = '0;
        i_decode_stall  = 1'b0;
        i_mem_valid     = 1'b0;
        i_mem_data      = '0;
        exp_pc          = RESET_PC;
        mem_line        = '0;
        mem_busy        = 1'b0;
        mem_delay       = 0;
        req_seen        = 1'b0;
        track_req       = 1'b1;
        req_rises       = 0;
        delivery_count  = 0;
        idle_cycles     = 0;
        check_count     = 0;
        error_count     = 0;
        repeat (5) @(posedge clk);
        #10;
        i_rst_n = 1'b1;

        sequential_stream();
        miss_refill();
        redirect_stream();
        decode_backpressure();
        mixed_random();

        $display("Checks: %0d, errors: %0d, delivered: %0d", check_count, error_count,
                 delivery_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
